//--- colmix_pkg.sv
`default_nettype none

package colmix_pkg;

    // layer codes, as the video chip tags each pixel
    localparam logic [2:0] lyr_obj  = 3'd0;
    localparam logic [2:0] lyr_scr1 = 3'd1;
    localparam logic [2:0] lyr_scr2 = 3'd2;
    localparam logic [2:0] lyr_scr3 = 3'd3;
    localparam logic [2:0] lyr_star = 3'd4;

    // entry fields, top down: group, layer code, colour index
    localparam int grp_w   = 2;
    localparam int code_w  = 3;
    localparam int idx_w   = 9;
    localparam int pen_w   = 4;
    localparam int entry_w = grp_w + code_w + idx_w;
    localparam int code_lo = idx_w;
    localparam int code_hi = idx_w + code_w - 1;
    localparam int grp_lo  = code_hi + 1;

    // palette address drops the group field
    localparam int pal_aw = code_w + idx_w;

    // pen 15 is see-through
    localparam logic [pen_w-1:0] pen_clear = 4'hf;

    // idle star entry, used at reset
    localparam logic [entry_w-1:0] star_clear = {2'b00, lyr_star, {idx_w{1'b1}}};

    // palette word: brightness, red, green, blue
    localparam int pal_dw    = 16;
    localparam int nib_w     = 4;
    localparam int pal_br_hi = 15;
    localparam int pal_r_hi  = 11;
    localparam int pal_g_hi  = 7;
    localparam int pal_b_hi  = 3;

    // scan length and the queue behind the first candidate
    localparam int num_layers = 6;
    localparam int queue_w    = (num_layers - 1) * entry_w;

endpackage

`default_nettype wire

//--- layer_select.sv
`timescale 1ns/10ps
`default_nettype none

module layer_select (
    input  wire        clk,
    input  wire        rst,
    input  wire        pxl_cen,
    input  wire [3:0]  gfx_en,
    input  wire [8:0]  obj_pxl,
    input  wire [10:0] scr1_pxl,
    input  wire [10:0] scr2_pxl,
    input  wire [10:0] scr3_pxl,
    input  wire [8:0]  star0_pxl,
    input  wire [8:0]  star1_pxl,
    input  wire [15:0] layer_ctrl,
    input  wire [7:0]  layer_mask0,
    input  wire [7:0]  layer_mask1,
    input  wire [7:0]  layer_mask2,
    input  wire [7:0]  layer_mask3,
    input  wire [7:0]  layer_mask4,
    output logic [colmix_pkg::entry_w-1:0] lyr0,
    output logic [colmix_pkg::entry_w-1:0] lyr1,
    output logic [colmix_pkg::entry_w-1:0] lyr2,
    output logic [colmix_pkg::entry_w-1:0] lyr3,
    output logic [colmix_pkg::entry_w-1:0] lyr4,
    output logic [colmix_pkg::entry_w-1:0] lyr5
);

    // layer enables from mask vs control word
    // bits 0..2 scroll 1..3, bits 3..4 stars
    logic [4:0] lyr_en;
    // entries a slot can pick by its 2-bit select
    logic [colmix_pkg::entry_w-1:0] src [4];
    logic [colmix_pkg::entry_w-1:0] star0_e, star1_e;

    // pen goes see-through when the layer is off
    function automatic logic [3:0] pen_gate(input logic [3:0] pen, input logic en);
        return en ? pen : colmix_pkg::pen_clear;
    endfunction

    assign lyr_en[0] = |(layer_mask0[5:0] & layer_ctrl[5:0]);
    assign lyr_en[1] = |(layer_mask1[5:0] & layer_ctrl[5:0]);
    assign lyr_en[2] = |(layer_mask2[5:0] & layer_ctrl[5:0]);
    assign lyr_en[3] = |(layer_mask3[5:0] & layer_ctrl[5:0]);
    assign lyr_en[4] = |(layer_mask4[5:0] & layer_ctrl[5:0]);

    // objects have only the gfx enable and no mask
    assign src[0] = {2'b00, colmix_pkg::lyr_obj, obj_pxl[8:4],
                     pen_gate(obj_pxl[3:0], gfx_en[3])};
    assign src[1] = {scr1_pxl[10:9], colmix_pkg::lyr_scr1, scr1_pxl[8:4],
                     pen_gate(scr1_pxl[3:0], lyr_en[0] & gfx_en[0])};
    assign src[2] = {scr2_pxl[10:9], colmix_pkg::lyr_scr2, scr2_pxl[8:4],
                     pen_gate(scr2_pxl[3:0], lyr_en[1] & gfx_en[1])};
    assign src[3] = {scr3_pxl[10:9], colmix_pkg::lyr_scr3, scr3_pxl[8:4],
                     pen_gate(scr3_pxl[3:0], lyr_en[2] & gfx_en[2])};

    // stars always group 0
    assign star0_e = {2'b00, colmix_pkg::lyr_star, star0_pxl[8:4],
                      pen_gate(star0_pxl[3:0], lyr_en[3])};
    assign star1_e = {2'b00, colmix_pkg::lyr_star, star1_pxl[8:4],
                      pen_gate(star1_pxl[3:0], lyr_en[4])};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lyr0 <= '1;
            lyr1 <= '1;
            lyr2 <= '1;
            lyr3 <= '1;
            lyr4 <= colmix_pkg::star_clear;
            lyr5 <= colmix_pkg::star_clear;
        end else if (pxl_cen) begin
            // layer_ctrl[13:6] orders the four upper slots with the top slot in [13:12]
            lyr0 <= src[layer_ctrl[13:12]];
            lyr1 <= src[layer_ctrl[11:10]];
            lyr2 <= src[layer_ctrl[9:8]];
            lyr3 <= src[layer_ctrl[7:6]];
            lyr4 <= star0_e;
            lyr5 <= star1_e;
        end
    end

endmodule

`default_nettype wire

//--- prio_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module prio_resolve (
    input  wire        clk,
    input  wire        rst,
    input  wire        pxl_cen,
    input  wire [colmix_pkg::entry_w-1:0] lyr0,
    input  wire [colmix_pkg::entry_w-1:0] lyr1,
    input  wire [colmix_pkg::entry_w-1:0] lyr2,
    input  wire [colmix_pkg::entry_w-1:0] lyr3,
    input  wire [colmix_pkg::entry_w-1:0] lyr4,
    input  wire [colmix_pkg::entry_w-1:0] lyr5,
    input  wire [15:0] prio0,
    input  wire [15:0] prio1,
    input  wire [15:0] prio2,
    input  wire [15:0] prio3,
    output logic [colmix_pkg::pal_aw-1:0] pal_addr
);

    // current candidate and its palette group
    logic [colmix_pkg::pal_aw-1:0] cand;
    logic [colmix_pkg::grp_w-1:0]  grp;
    // candidate came from a scroll/obj entry of the queue
    logic                          check_prio;
    // pending entries, lowest layer in the low slot
    logic [colmix_pkg::queue_w-1:0] queue;
    logic [colmix_pkg::entry_w-1:0] nxt;
    logic [15:0] prio_word;
    logic        has_prio;
    logic        take_nxt;

    assign nxt = queue[colmix_pkg::entry_w-1:0];

    // per-group mask, one bit per pen
    always_comb begin
        case (grp)
            2'd0:    prio_word = prio0;
            2'd1:    prio_word = prio1;
            2'd2:    prio_word = prio2;
            default: prio_word = prio3;
        endcase
    end

    assign has_prio = prio_word[cand[colmix_pkg::pen_w-1:0]];

    // see-through candidate always loses
    // otherwise an opaque entry wins unless it is an object under a priority tile
    assign take_nxt =
        (cand[colmix_pkg::pen_w-1:0] == colmix_pkg::pen_clear) ||
        ((nxt[colmix_pkg::pen_w-1:0] != colmix_pkg::pen_clear) &&
         !((nxt[colmix_pkg::code_hi:colmix_pkg::code_lo] == colmix_pkg::lyr_obj) &&
           has_prio && check_prio));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr   <= '1;
            cand       <= '1;
            grp        <= '0;
            check_prio <= 1'b0;
            queue      <= '1;
        end else if (pxl_cen) begin
            // last scan result out, new pixel in
            pal_addr    <= cand;
            {grp, cand} <= lyr5;
            queue       <= {lyr0, lyr1, lyr2, lyr3, lyr4};
            check_prio  <= 1'b0;
        end else begin
            if (take_nxt) begin
                {grp, cand} <= nxt;
                // stars never carry priority
                check_prio  <= nxt[colmix_pkg::code_hi:colmix_pkg::code_lo]
                               != colmix_pkg::lyr_star;
            end
            // shift one entry per clock, refill see-through
            queue <= {{colmix_pkg::entry_w{1'b1}},
                      queue[colmix_pkg::queue_w-1:colmix_pkg::entry_w]};
        end
    end

    // scan only runs between strobes, back-to-back strobes would skip it
    a_cen_gap: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen);

endmodule

`default_nettype wire

//--- palette_ram.sv
`timescale 1ns/10ps
`default_nettype none

module palette_ram (
    input  wire        clk,
    input  wire        pal_we,
    input  wire [colmix_pkg::pal_aw-1:0] pal_wr_addr,
    input  wire [colmix_pkg::pal_dw-1:0] pal_wr_data,
    input  wire [colmix_pkg::pal_aw-1:0] pal_addr,
    output logic [colmix_pkg::pal_dw-1:0] pal_data
);

    // one word per palette entry
    logic [colmix_pkg::pal_dw-1:0] mem [1 << colmix_pkg::pal_aw];

    // cpu side write
    always_ff @(posedge clk) begin
        if (pal_we) begin
            mem[pal_wr_addr] <= pal_wr_data;
        end
    end

    // video side read, one clock
    // same-address write shows the old word
    always_ff @(posedge clk) begin
        pal_data <= mem[pal_addr];
    end

endmodule

`default_nettype wire

//--- bright_out.sv
`timescale 1ns/10ps
`default_nettype none

module bright_out (
    input  wire        clk,
    input  wire        rst,
    input  wire        pxl_cen,
    input  wire        vb,
    input  wire        hb,
    input  wire [colmix_pkg::pal_dw-1:0] pal_data,
    output logic       lvbl,
    output logic       lhbl,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    // palette word fields
    logic [colmix_pkg::nib_w-1:0] raw_br, raw_r, raw_g, raw_b;
    logic [colmix_pkg::nib_w-1:0] inv_br;
    // nibbles delayed to line up with the products
    logic [colmix_pkg::nib_w-1:0] dly_r, dly_g, dly_b;
    logic [7:0] mul_r, mul_g, mul_b;
    // blanking delay with the oldest pixel in bit 2
    logic [2:0] vb_dly, hb_dly;
    logic       blank;

    // c*17 - c*(15-b)/2 - c*(15-b)/4
    function automatic logic [7:0] atten(input logic [3:0] c, input logic [7:0] m);
        return {c, c} - (m >> 1) - (m >> 2);
    endfunction

    assign raw_br = pal_data[colmix_pkg::pal_br_hi -: colmix_pkg::nib_w];
    assign raw_r  = pal_data[colmix_pkg::pal_r_hi -: colmix_pkg::nib_w];
    assign raw_g  = pal_data[colmix_pkg::pal_g_hi -: colmix_pkg::nib_w];
    assign raw_b  = pal_data[colmix_pkg::pal_b_hi -: colmix_pkg::nib_w];
    assign inv_br = ~raw_br;

    // free-running products sampled at the next strobe
    always_ff @(posedge clk) begin
        mul_r <= raw_r * inv_br;
        mul_g <= raw_g * inv_br;
        mul_b <= raw_b * inv_br;
        dly_r <= raw_r;
        dly_g <= raw_g;
        dly_b <= raw_b;
    end

    // blank on vb or on the first pixel of hb
    assign blank = vb_dly[2] || (hb_dly[2] && lhbl);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // start out blanked
            vb_dly <= '1;
            hb_dly <= '1;
            lvbl   <= 1'b0;
            lhbl   <= 1'b0;
            red    <= 8'd0;
            green  <= 8'd0;
            blue   <= 8'd0;
        end else if (pxl_cen) begin
            vb_dly <= {vb_dly[1:0], vb};
            hb_dly <= {hb_dly[1:0], hb};
            lvbl   <= ~vb_dly[2];
            lhbl   <= ~hb_dly[2];
            if (blank) begin
                red   <= 8'd0;
                green <= 8'd0;
                blue  <= 8'd0;
            end else begin
                red   <= atten(dly_r, mul_r);
                green <= atten(dly_g, mul_g);
                blue  <= atten(dly_b, mul_b);
            end
        end
    end

    // palette word lands one clock after the strobe and the products one clock later
    a_product_gap: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |-> !$past(pxl_cen) && !$past(pxl_cen, 2));

endmodule

`default_nettype wire

//--- colmix_top.sv
`timescale 1ns/10ps
`default_nettype none

module colmix_top (
    input  wire        clk,
    input  wire        rst,
    input  wire        pxl_cen,
    input  wire        vb,
    input  wire        hb,
    input  wire [3:0]  gfx_en,
    input  wire [8:0]  obj_pxl,
    input  wire [10:0] scr1_pxl,
    input  wire [10:0] scr2_pxl,
    input  wire [10:0] scr3_pxl,
    input  wire [8:0]  star0_pxl,
    input  wire [8:0]  star1_pxl,
    input  wire [15:0] layer_ctrl,
    input  wire [7:0]  layer_mask0,
    input  wire [7:0]  layer_mask1,
    input  wire [7:0]  layer_mask2,
    input  wire [7:0]  layer_mask3,
    input  wire [7:0]  layer_mask4,
    input  wire [15:0] prio0,
    input  wire [15:0] prio1,
    input  wire [15:0] prio2,
    input  wire [15:0] prio3,
    input  wire        pal_we,
    input  wire [colmix_pkg::pal_aw-1:0] pal_wr_addr,
    input  wire [colmix_pkg::pal_dw-1:0] pal_wr_data,
    output wire        lvbl,
    output wire        lhbl,
    output wire [7:0]  red,
    output wire [7:0]  green,
    output wire [7:0]  blue
);

    // ordered entries, lyr0 on top
    logic [colmix_pkg::entry_w-1:0] lyr0, lyr1, lyr2, lyr3, lyr4, lyr5;
    logic [colmix_pkg::pal_aw-1:0]  pal_addr;
    logic [colmix_pkg::pal_dw-1:0]  pal_data;

    // strobe k: mask and order
    layer_select u_select (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .gfx_en      (gfx_en),
        .obj_pxl     (obj_pxl),
        .scr1_pxl    (scr1_pxl),
        .scr2_pxl    (scr2_pxl),
        .scr3_pxl    (scr3_pxl),
        .star0_pxl   (star0_pxl),
        .star1_pxl   (star1_pxl),
        .layer_ctrl  (layer_ctrl),
        .layer_mask0 (layer_mask0),
        .layer_mask1 (layer_mask1),
        .layer_mask2 (layer_mask2),
        .layer_mask3 (layer_mask3),
        .layer_mask4 (layer_mask4),
        .lyr0        (lyr0),
        .lyr1        (lyr1),
        .lyr2        (lyr2),
        .lyr3        (lyr3),
        .lyr4        (lyr4),
        .lyr5        (lyr5)
    );

    // strobe k+1 to k+2: serial scan
    prio_resolve u_prio (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lyr0     (lyr0),
        .lyr1     (lyr1),
        .lyr2     (lyr2),
        .lyr3     (lyr3),
        .lyr4     (lyr4),
        .lyr5     (lyr5),
        .prio0    (prio0),
        .prio1    (prio1),
        .prio2    (prio2),
        .prio3    (prio3),
        .pal_addr (pal_addr)
    );

    palette_ram u_pal (
        .clk         (clk),
        .pal_we      (pal_we),
        .pal_wr_addr (pal_wr_addr),
        .pal_wr_data (pal_wr_data),
        .pal_addr    (pal_addr),
        .pal_data    (pal_data)
    );

    // strobe k+3: colour out
    bright_out u_bright (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .vb       (vb),
        .hb       (hb),
        .pal_data (pal_data),
        .lvbl     (lvbl),
        .lhbl     (lhbl),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

`default_nettype wire

//--- colmix_checker.sv
`timescale 1ns/10ps
`default_nettype none

module colmix_checker (
    input  wire        clk,
    input  wire        rst,
    input  wire        pxl_cen,
    input  wire        vb,
    input  wire        hb,
    input  wire [3:0]  gfx_en,
    input  wire [8:0]  obj_pxl,
    input  wire [10:0] scr1_pxl,
    input  wire [10:0] scr2_pxl,
    input  wire [10:0] scr3_pxl,
    input  wire [8:0]  star0_pxl,
    input  wire [8:0]  star1_pxl,
    input  wire [15:0] layer_ctrl,
    input  wire [7:0]  layer_mask0,
    input  wire [7:0]  layer_mask1,
    input  wire [7:0]  layer_mask2,
    input  wire [7:0]  layer_mask3,
    input  wire [7:0]  layer_mask4,
    input  wire [15:0] prio0,
    input  wire [15:0] prio1,
    input  wire [15:0] prio2,
    input  wire [15:0] prio3,
    input  wire        pal_we,
    input  wire [11:0] pal_wr_addr,
    input  wire [15:0] pal_wr_data,
    input  wire        lvbl,
    input  wire        lhbl,
    input  wire [7:0]  red,
    input  wire [7:0]  green,
    input  wire [7:0]  blue,
    output int         err_count,
    output int         check_count
);

    // idle clocks between strobes, each one scan step
    localparam int scan_steps = 7;

    logic [15:0] pal_copy [4096];
    // six entries per pixel, lyr0 in the top bits
    logic [83:0] ent_q [$];
    // {vb, hb} and {r, g, b} waiting for their output strobe
    logic [1:0]  blk_q [$];
    logic [23:0] col_q [$];
    logic        prev_hb;
    logic [15:0] word;
    logic [23:0] col;
    logic [1:0]  old_blk;
    logic [23:0] exp_col;
    logic        exp_lvbl;
    logic        exp_lhbl;
    int          strobe_count;

    function automatic logic [3:0] shown_pen(input logic [3:0] pen, input logic on);
        if (on) begin
            return pen;
        end
        return 4'hf;
    endfunction

    // masking and slot order from the current inputs
    function automatic logic [83:0] order_layers();
        logic [13:0] pick [4];
        logic [13:0] s0;
        logic [13:0] s1;
        logic        on1;
        logic        on2;
        logic        on3;
        on1 = gfx_en[0] && (layer_mask0[5:0] & layer_ctrl[5:0]) != 6'd0;
        on2 = gfx_en[1] && (layer_mask1[5:0] & layer_ctrl[5:0]) != 6'd0;
        on3 = gfx_en[2] && (layer_mask2[5:0] & layer_ctrl[5:0]) != 6'd0;
        pick[0] = {2'b00, colmix_pkg::lyr_obj, obj_pxl[8:4],
                   shown_pen(obj_pxl[3:0], gfx_en[3])};
        pick[1] = {scr1_pxl[10:9], colmix_pkg::lyr_scr1, scr1_pxl[8:4],
                   shown_pen(scr1_pxl[3:0], on1)};
        pick[2] = {scr2_pxl[10:9], colmix_pkg::lyr_scr2, scr2_pxl[8:4],
                   shown_pen(scr2_pxl[3:0], on2)};
        pick[3] = {scr3_pxl[10:9], colmix_pkg::lyr_scr3, scr3_pxl[8:4],
                   shown_pen(scr3_pxl[3:0], on3)};
        s0 = {2'b00, colmix_pkg::lyr_star, star0_pxl[8:4],
              shown_pen(star0_pxl[3:0], (layer_mask3[5:0] & layer_ctrl[5:0]) != 6'd0)};
        s1 = {2'b00, colmix_pkg::lyr_star, star1_pxl[8:4],
              shown_pen(star1_pxl[3:0], (layer_mask4[5:0] & layer_ctrl[5:0]) != 6'd0)};
        return {pick[layer_ctrl[13:12]], pick[layer_ctrl[11:10]],
                pick[layer_ctrl[9:8]], pick[layer_ctrl[7:6]], s0, s1};
    endfunction

    // bottom entry first, then upward, then see-through refill
    function automatic logic [11:0] scan_layers(input logic [83:0] e);
        logic [13:0] cur;
        logic [13:0] nxt;
        logic [15:0] mask;
        logic        chk;
        logic        counted;
        cur = e[13:0];
        chk = 1'b0;
        for (int i = 0; i < scan_steps; i++) begin
            nxt = (i < 5) ? e[14*(i+1) +: 14] : 14'h3fff;
            case (cur[13:12])
                2'd0:    mask = prio0;
                2'd1:    mask = prio1;
                2'd2:    mask = prio2;
                default: mask = prio3;
            endcase
            counted = chk && mask[cur[3:0]];
            if (cur[3:0] == 4'hf || (nxt[3:0] != 4'hf &&
                    !(nxt[11:9] == colmix_pkg::lyr_obj && counted))) begin
                cur = nxt;
                chk = nxt[11:9] != colmix_pkg::lyr_star;
            end
        end
        return cur[11:0];
    endfunction

    // brightness scaling of one nibble
    function automatic logic [7:0] scale(input logic [3:0] c, input logic [3:0] b);
        int ci;
        int m;
        int v;
        ci = 32'(c);
        m = (ci * (15 - 32'(b))) % 256;
        v = ci * 17 - m / 2 - m / 4;
        return v[7:0];
    endfunction

    always @(posedge clk) begin
        if (pal_we) begin
            pal_copy[pal_wr_addr] <= pal_wr_data;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            // three blanked pixels ahead of the first real one
            ent_q.delete();
            blk_q = '{2'b11, 2'b11, 2'b11};
            col_q = '{24'd0, 24'd0, 24'd0};
            prev_hb = 1'b1;
        end else if (pxl_cen) begin
            ent_q.push_back(order_layers());
            blk_q.push_back({vb, hb});
            // previous pixel is scanned now, with the prio words sampled here
            if (ent_q.size() == 2) begin
                word = pal_copy[scan_layers(ent_q.pop_front())];
                col_q.push_back({scale(word[11:8], word[15:12]),
                                 scale(word[7:4], word[15:12]),
                                 scale(word[3:0], word[15:12])});
            end
            old_blk = blk_q.pop_front();
            col = col_q.pop_front();
            exp_lvbl = !old_blk[1];
            exp_lhbl = !old_blk[0];
            exp_col = (old_blk[1] || (old_blk[0] && !prev_hb)) ? 24'd0 : col;
            prev_hb = old_blk[0];
            strobe_count = strobe_count + 1;
        end
    end

    // outputs settle after the strobe edge
    always @(negedge clk) begin
        if (!rst && strobe_count != check_count) begin
            check_count = strobe_count;
            if ({red, green, blue} !== exp_col || lvbl !== exp_lvbl || lhbl !== exp_lhbl) begin
                err_count = err_count + 1;
                $display("** Error at %0t: rgb %h %h %h lvbl %b lhbl %b", $time,
                         red, green, blue, lvbl, lhbl);
                $display("   expected rgb %h %h %h lvbl %b lhbl %b",
                         exp_col[23:16], exp_col[15:8], exp_col[7:0], exp_lvbl, exp_lhbl);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_colmix.sv
`timescale 1ns/10ps
`default_nettype none

module tb_colmix;

    localparam int pxl_period = 8;
    localparam int phase_pixels = 300;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        vb;
    logic        hb;
    logic [3:0]  gfx_en;
    logic [8:0]  obj_pxl;
    logic [10:0] scr1_pxl;
    logic [10:0] scr2_pxl;
    logic [10:0] scr3_pxl;
    logic [8:0]  star0_pxl;
    logic [8:0]  star1_pxl;
    logic [15:0] layer_ctrl;
    logic [7:0]  layer_mask0;
    logic [7:0]  layer_mask1;
    logic [7:0]  layer_mask2;
    logic [7:0]  layer_mask3;
    logic [7:0]  layer_mask4;
    logic [15:0] prio0;
    logic [15:0] prio1;
    logic [15:0] prio2;
    logic [15:0] prio3;
    logic        pal_we;
    logic [11:0] pal_wr_addr;
    logic [15:0] pal_wr_data;
    logic        lvbl;
    logic        lhbl;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    int          err_count;
    int          check_count;
    // stimulus bookkeeping
    int          pixels_sent;
    int          line_pos;
    int          line_num;
    int          wait_cnt;
    logic [31:0] rnd;

    colmix_top UUT (.*);

    colmix_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random layer pixel, see-through about one time in three
    function automatic logic [10:0] rand_pixel();
        logic [31:0] r;
        r = $urandom();
        if (r[31:16] % 3 == 0) begin
            r[3:0] = 4'hf;
        end
        return r[10:0];
    endfunction

    // one pixel: drive, strobe, then idle clocks for the scan
    // mode 0 all layers on, 1 layers cleared, 2 priority tiles, 3 anything
    task automatic send_pixel(input int mode);
        @(posedge clk);
        #1;
        obj_pxl   = 9'(rand_pixel());
        scr1_pxl  = rand_pixel();
        scr2_pxl  = rand_pixel();
        scr3_pxl  = rand_pixel();
        star0_pxl = 9'(rand_pixel());
        star1_pxl = 9'(rand_pixel());
        gfx_en     = (mode == 0 || mode == 2) ? 4'hf : 4'($urandom());
        layer_ctrl = 16'($urandom());
        layer_mask0 = 8'($urandom()) & 8'($urandom());
        layer_mask1 = 8'($urandom()) & 8'($urandom());
        layer_mask2 = 8'($urandom()) & 8'($urandom());
        layer_mask3 = 8'($urandom()) & 8'($urandom());
        layer_mask4 = 8'($urandom()) & 8'($urandom());
        prio0 = (mode == 0) ? 16'h0000 : 16'($urandom());
        prio1 = (mode == 0) ? 16'h0000 : 16'($urandom());
        prio2 = (mode == 2) ? 16'hffff : 16'($urandom());
        prio3 = (mode == 2) ? 16'hffff : 16'($urandom());
        if (mode == 0 || mode == 2) begin
            // every mask hits the control bits
            layer_ctrl[5:0] = 6'h3f;
            layer_mask0[0] = 1'b1;
            layer_mask1[0] = 1'b1;
            layer_mask2[0] = 1'b1;
            layer_mask3[0] = 1'b1;
            layer_mask4[0] = 1'b1;
        end
        if (mode == 1 && pixels_sent % 8 == 0) begin
            // nothing left enabled at all
            gfx_en = 4'h0;
            layer_mask0 = 8'h00;
            layer_mask1 = 8'h00;
            layer_mask2 = 8'h00;
            layer_mask3 = 8'h00;
            layer_mask4 = 8'h00;
        end
        if (mode == 2 && obj_pxl[3:0] == 4'hf) begin
            obj_pxl[3:0] = 4'h0;
        end
        // 20 pixel line with 4 blanked, 12 line frame with 2 blanked
        hb = line_pos >= 16;
        vb = line_num >= 10;
        line_pos = (line_pos + 1) % 20;
        if (line_pos == 0) begin
            line_num = (line_num + 1) % 12;
        end
        pxl_cen = 1'b1;
        @(posedge clk);
        #1;
        pxl_cen = 1'b0;
        pixels_sent = pixels_sent + 1;
        repeat (pxl_period - 2) @(posedge clk);
    endtask

    initial begin
        rnd = $urandom(32'hbf4f);
        rst = 1'b1;
        pxl_cen = 1'b0;
        vb = 1'b1;
        hb = 1'b1;
        gfx_en = 4'h0;
        obj_pxl = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        scr3_pxl = '0;
        star0_pxl = '0;
        star1_pxl = '0;
        layer_ctrl = '0;
        layer_mask0 = '0;
        layer_mask1 = '0;
        layer_mask2 = '0;
        layer_mask3 = '0;
        layer_mask4 = '0;
        prio0 = '0;
        prio1 = '0;
        prio2 = '0;
        prio3 = '0;
        pal_we = 1'b0;
        pal_wr_addr = '0;
        pal_wr_data = '0;
        pixels_sent = 0;
        line_pos = 0;
        line_num = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // whole palette, quarter of it at brightness 0 and another at 15
        for (int a = 0; a < 4096; a++) begin
            @(posedge clk);
            #1;
            rnd = $urandom();
            pal_we = 1'b1;
            pal_wr_addr = 12'(a);
            pal_wr_data = rnd[15:0];
            if (a % 4 == 0) begin
                pal_wr_data[15:12] = 4'h0;
            end else if (a % 4 == 1) begin
                pal_wr_data[15:12] = 4'hf;
            end
        end
        @(posedge clk);
        #1;
        pal_we = 1'b0;
        for (int m = 0; m < 4; m++) begin
            repeat (phase_pixels) send_pixel(m);
        end
        // flush the three-strobe pipeline
        repeat (3) send_pixel(0);
        wait_cnt = 0;
        while (check_count < pixels_sent && wait_cnt < 100) begin
            @(posedge clk);
            wait_cnt = wait_cnt + 1;
        end
        if (check_count < pixels_sent) begin
            $display("timed out waiting for the checker to see every pixel strobe");
            $display("errors: %0d, checks: %0d", err_count, check_count);
            $display("Test FAILED");
        end else begin
            $display("errors: %0d, checks: %0d", err_count, check_count);
            if (err_count == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- colmix.f
colmix_pkg.sv
layer_select.sv
prio_resolve.sv
palette_ram.sv
bright_out.sv
colmix_top.sv
colmix_checker.sv
tb_colmix.sv

//--- Makefile
LOG = sim.log

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_colmix -Mdir obj_dir -f colmix.f
	./obj_dir/Vtb_colmix | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
